//--- bus_mapper.f
+incdir+sim
hw/mapper_pkg.sv
hw/mapper_regs.sv
hw/region_decode.sv
hw/wait_state_gen.sv
hw/irq_ctrl.sv
hw/bus_mapper.sv
sim/bus_mapper_tb.sv

//--- Bender.yml
package:
  name: bus_mapper

sources:
  # synthesizable mapper
  - files:
      - hw/mapper_pkg.sv
      - hw/mapper_regs.sv
      - hw/region_decode.sv
      - hw/wait_state_gen.sv
      - hw/irq_ctrl.sv
      - hw/bus_mapper.sv

  # testbench, pulls in sim/mapper_ref.svh
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/bus_mapper_tb.sv

//--- sim/mapper_ref.svh
`ifndef mapper_ref_svh
`define mapper_ref_svh

// shadow of the mapper register file that follows every unmatched write
logic [7:0] shadow_regs [reg_count];

function automatic void ref_clear();
    for (int i = 0; i < reg_count; i++) begin
        shadow_regs[i] = 8'h00;
    end
endfunction

// region table as the cpu programmed it
// size/wait byte holds wait code in bits 3:2 and size code in bits 1:0
function automatic region_cfg_t ref_region(input int r);
    region_cfg_t c;
    c.base      = shadow_regs[region_reg_base + 2 * r + 1];
    c.size      = shadow_regs[region_reg_base + 2 * r][1:0];
    c.wait_code = shadow_regs[region_reg_base + 2 * r][3:2];
    return c;
endfunction

// size code 0..3 compares 8, 7, 5 or 3 top bits
function automatic logic ref_match(input logic [7:0] top, input region_cfg_t c);
    int sh;
    sh = (c.size == 2'd0) ? 0 : (c.size == 2'd1) ? 1 : (c.size == 2'd2) ? 3 : 5;
    return (top >> sh) == (c.base >> sh);
endfunction

// expected response where the lowest region index wins and iack never hits
function automatic map_rsp_t ref_decode(input bus_req_t r);
    map_rsp_t m;
    m.hit    = 1'b0;
    m.region = rgn_prog_rom;
    m.kind   = (r.fc == 3'b111) ? acc_iack : (r.write ? acc_write : acc_read);
    if (m.kind != acc_iack) begin
        for (int i = 0; i < num_regions; i++) begin
            if (!m.hit && ref_match(r.addr[23:16], ref_region(i))) begin
                m.hit    = 1'b1;
                m.region = region_e'(3'(i));
            end
        end
    end
    return m;
endfunction

// edges from sampling to ack for wait codes 0 to 2
function automatic int ref_latency(input bus_req_t r);
    map_rsp_t    m;
    region_cfg_t c;
    m = ref_decode(r);
    c = ref_region(int'(m.region));
    return m.hit ? int'(c.wait_code) + 2 : 2;
endfunction

// unmatched write lands at addr bits 5:1
function automatic void ref_commit(input bus_req_t r);
    map_rsp_t m;
    m = ref_decode(r);
    if ((m.kind == acc_write) && !m.hit) begin
        shadow_regs[r.addr[5:1]] = r.wdata[7:0];
    end
endfunction

task automatic check_rsp(input string name, input map_rsp_t exp_v, input map_rsp_t act_v);
    if (act_v !== exp_v) begin
        $write("ERROR %0t %s expected hit=%0b region=%0d kind=%0d",
               $time, name, exp_v.hit, exp_v.region, exp_v.kind);
        $display(" actual hit=%0b region=%0d kind=%0d",
                 act_v.hit, act_v.region, act_v.kind);
        report_failure();
    end
endtask

task automatic check_latency(input string name, input int exp_v, input int act_v);
    if (act_v != exp_v) begin
        $display("ERROR %0t %s expected %0d actual %0d", $time, name, exp_v, act_v);
        report_failure();
    end
endtask

task automatic check_byte(input string name, input logic [7:0] exp_v, input logic [7:0] act_v);
    if (act_v !== exp_v) begin
        $display("ERROR %0t %s expected %h actual %h", $time, name, exp_v, act_v);
        report_failure();
    end
endtask

task automatic check_flag(input string name, input logic exp_v, input logic act_v);
    if (act_v !== exp_v) begin
        $display("ERROR %0t %s expected %b actual %b", $time, name, exp_v, act_v);
        report_failure();
    end
endtask

`endif

//--- sim/bus_mapper_tb.sv
module bus_mapper_tb
    import mapper_pkg::*;
();

    localparam int reset_cycles = 16;
    // 4 after reset, 16 programming, 24 random, 2 ext ready, 1 latch, 1 iack
    localparam int n_transfers = 48;
    localparam int cycle_limit = 20 * n_transfers + reset_cycles;

    logic       clk;
    logic       rst;
    logic       req;
    bus_req_t   bus_req;
    logic       ext_ready;
    logic       vint;
    logic       snd_rd;
    logic       ack;
    map_rsp_t   rsp;
    logic [7:0] snd_dout;
    logic       snd_full;
    logic       irq_pending;

    int         cycle_cnt = 0;
    int         checked = 0;
    // expected and observed results, one entry per transfer
    map_rsp_t   exp_rsp_q [$];
    int         exp_lat_q [$];
    map_rsp_t   act_rsp_q [$];
    int         act_lat_q [$];

    task automatic report_failure();
        $display("Verification failed");
        $fatal(1, "run stopped at the first failure");
    endtask

    `include "mapper_ref.svh"

    bus_mapper bus_mapper_inst (
        .clk         (clk),
        .rst         (rst),
        .req         (req),
        .bus_req     (bus_req),
        .ext_ready   (ext_ready),
        .vint        (vint),
        .snd_rd      (snd_rd),
        .ack         (ack),
        .rsp         (rsp),
        .snd_dout    (snd_dout),
        .snd_full    (snd_full),
        .irq_pending (irq_pending)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // hard stop if the handshake stalls
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("timeout: test still running after %0d cycles", cycle_cnt);
            report_failure();
        end
    end

    // four-phase cycle, entered and left 2 units after an edge
    task automatic run_cycle(input bus_req_t r, output map_rsp_t seen, output int lat);
        bus_req = r;
        req     = 1'b1;
        // next edge samples the request
        @(posedge clk);
        lat = 0;
        do begin
            @(posedge clk);
            #1;
            lat++;
        end while (!ack);
        seen = rsp;
        #1;
        req = 1'b0;
        do begin
            @(posedge clk);
            #1;
        end while (ack);
        #1;
    endtask

    task automatic transfer(input bus_req_t r);
        map_rsp_t seen;
        int       lat;
        exp_rsp_q.push_back(ref_decode(r));
        exp_lat_q.push_back(ref_latency(r));
        run_cycle(r, seen, lat);
        act_rsp_q.push_back(seen);
        act_lat_q.push_back(lat);
        ref_commit(r);
    endtask

    // top address bit set, bases keep bit 7 clear, so always a miss
    task automatic write_reg(input logic [4:0] idx, input logic [7:0] value);
        bus_req_t r;
        r.addr  = {1'b1, 17'($urandom), idx};
        r.wdata = {8'($urandom), value};
        r.write = 1'b1;
        r.fc    = 3'b101;
        transfer(r);
    endtask

    // half aimed near a programmed base, half anywhere
    task automatic random_access();
        bus_req_t    r;
        region_cfg_t c;
        logic [4:0]  idx;
        c   = ref_region(int'($urandom % num_regions));
        idx = 5'($urandom % 16);
        // keep the sound latch out of it
        if (idx == 5'(snd_latch_idx)) begin
            idx = 5'd2;
        end
        r.addr = {8'($urandom), 10'($urandom), idx};
        if ($urandom % 2) begin
            r.addr[23:16] = c.base ^ 8'($urandom % 32);
        end
        r.wdata = 16'($urandom);
        r.write = 1'($urandom);
        r.fc    = 3'($urandom % 7);
        transfer(r);
    endtask

    // compares each finished transfer against the reference
    initial begin
        forever begin
            wait (act_lat_q.size() != 0);
            check_rsp("rsp", exp_rsp_q.pop_front(), act_rsp_q.pop_front());
            check_latency("ack latency", exp_lat_q.pop_front(), act_lat_q.pop_front());
            checked++;
        end
    end

    initial begin
        bus_req_t    r;
        map_rsp_t    seen;
        region_cfg_t c0;
        logic [7:0]  snd_byte;
        int          lat;
        int          d;
        rst       = 1'b1;
        req       = 1'b0;
        bus_req   = '0;
        ext_ready = 1'b0;
        vint      = 1'b0;
        snd_rd    = 1'b0;
        void'($urandom(7155));
        ref_clear();
        repeat (reset_cycles) @(posedge clk);
        #2;
        rst = 1'b0;

        check_flag("ack", 1'b0, ack);
        check_flag("snd_full", 1'b0, snd_full);
        check_flag("irq_pending", 1'b0, irq_pending);
        // empty table, only top byte zero reaches region 0
        for (int i = 0; i < 4; i++) begin
            r.addr        = 23'($urandom);
            r.addr[23:16] = (i == 3) ? 8'h00 : (8'h01 | 8'($urandom));
            r.wdata       = '0;
            r.write       = 1'b0;
            r.fc          = 3'b110;
            transfer(r);
        end

        // size/wait byte then base, wait codes 0 to 2
        for (int i = 0; i < num_regions; i++) begin
            write_reg(5'(region_reg_base + 2 * i), {4'($urandom), 2'($urandom % 3), 2'($urandom)});
            write_reg(5'(region_reg_base + 2 * i + 1), {1'b0, 7'($urandom)});
        end
        for (int i = 0; i < 24; i++) begin
            random_access();
        end

        // region 0 switched to external ready
        c0 = ref_region(0);
        write_reg(5'(region_reg_base), {4'h0, 2'd3, c0.size});
        d = 2 + int'($urandom % 8);
        r.addr  = {c0.base, 15'($urandom)};
        r.wdata = '0;
        r.write = 1'b0;
        r.fc    = 3'b110;
        exp_rsp_q.push_back(ref_decode(r));
        exp_lat_q.push_back(d + 1);
        fork
            run_cycle(r, seen, lat);
            begin
                repeat (d + 1) @(posedge clk);
                #2;
                ext_ready = 1'b1;
                @(posedge clk);
                #2;
                ext_ready = 1'b0;
            end
        join
        act_rsp_q.push_back(seen);
        act_lat_q.push_back(lat);

        // sound latch fill and drain
        snd_byte = 8'($urandom);
        write_reg(5'(snd_latch_idx), snd_byte);
        check_flag("snd_full", 1'b1, snd_full);
        check_byte("snd_dout", snd_byte, snd_dout);
        snd_rd = 1'b1;
        @(posedge clk);
        #2;
        snd_rd = 1'b0;
        check_flag("snd_full", 1'b0, snd_full);

        // vblank edge, pending two edges later
        vint = 1'b1;
        @(posedge clk);
        #2;
        check_flag("irq_pending", 1'b0, irq_pending);
        @(posedge clk);
        #2;
        check_flag("irq_pending", 1'b1, irq_pending);
        vint    = 1'b0;
        r.addr  = 23'($urandom);
        r.wdata = '0;
        r.write = 1'b0;
        r.fc    = 3'b111;
        transfer(r);
        check_flag("irq_pending", 1'b0, irq_pending);

        repeat (2) @(posedge clk);
        if ((checked == n_transfers) && (exp_lat_q.size() == 0)) begin
            $display("Verification passed");
            $finish;
        end else begin
            $display("only %0d of %0d transfers were checked", checked, n_transfers);
            report_failure();
        end
    end

endmodule

//--- hw/bus_mapper.sv
module bus_mapper
    import mapper_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       req,
    input  bus_req_t   bus_req,
    input  logic       ext_ready,
    input  logic       vint,
    input  logic       snd_rd,
    output logic       ack,
    output map_rsp_t   rsp,
    output logic [7:0] snd_dout,
    output logic       snd_full,
    output logic       irq_pending
);

    // decode to wait stage
    logic        dec_valid;
    dec_t        dec;
    // region table from the register file
    region_cfg_t cfg [num_regions];
    // commits out of the wait stage
    logic        reg_commit;
    logic        iack_commit;
    logic [4:0]  reg_idx;
    logic [7:0]  wbyte;

    // capture and prioritized match
    region_decode region_decode_inst (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .ack       (ack),
        .bus_req   (bus_req),
        .cfg       (cfg),
        .dec_valid (dec_valid),
        .dec       (dec)
    );

    // wait states and the ack handshake
    wait_state_gen wait_state_gen_inst (
        .clk         (clk),
        .rst         (rst),
        .req         (req),
        .dec_valid   (dec_valid),
        .dec         (dec),
        .ext_ready   (ext_ready),
        .ack         (ack),
        .rsp         (rsp),
        .reg_commit  (reg_commit),
        .iack_commit (iack_commit),
        .reg_idx     (reg_idx),
        .wbyte       (wbyte)
    );

    mapper_regs mapper_regs_inst (
        .clk      (clk),
        .rst      (rst),
        .commit   (reg_commit),
        .reg_idx  (reg_idx),
        .wbyte    (wbyte),
        .snd_rd   (snd_rd),
        .cfg      (cfg),
        .snd_dout (snd_dout),
        .snd_full (snd_full)
    );

    // vblank interrupt
    irq_ctrl irq_ctrl_inst (
        .clk         (clk),
        .rst         (rst),
        .vint        (vint),
        .iack_commit (iack_commit),
        .irq_pending (irq_pending)
    );

endmodule

//--- hw/irq_ctrl.sv
module irq_ctrl
    import mapper_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic vint,
    input  logic iack_commit,
    output logic irq_pending
);

    // vint sampled, then delayed once for the edge check
    logic vint_q;
    logic vint_d;
    logic vint_rise;

    assign vint_rise = vint_q && !vint_d;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vint_q      <= 1'b0;
            vint_d      <= 1'b0;
            irq_pending <= 1'b0;
        end else begin
            vint_q <= vint;
            vint_d <= vint_q;
            // acknowledge wins over a fresh edge
            if (iack_commit) begin
                irq_pending <= 1'b0;
            end else if (vint_rise) begin
                // level 4 request toward the cpu
                irq_pending <= 1'b1;
            end
        end
    end

endmodule

//--- hw/wait_state_gen.sv
module wait_state_gen
    import mapper_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       req,
    input  logic       dec_valid,
    input  dec_t       dec,
    input  logic       ext_ready,
    output logic       ack,
    output map_rsp_t   rsp,
    output logic       reg_commit,
    output logic       iack_commit,
    output logic [4:0] reg_idx,
    output logic [7:0] wbyte
);

    wait_state_e state;
    // decode held for the length of the wait
    dec_t        cur;
    // live view, straight from decode while idle
    dec_t        cur_d;
    logic [1:0]  cnt;
    // ack goes high on this edge
    logic        fire;

    assign cur_d = (state == ws_idle) ? dec : cur;

    always_comb begin
        fire = 1'b0;
        case (state)
            ws_idle: begin
                // code 0 acks at once, code 3 may already see ready
                fire = dec_valid && ((dec.wait_code == 2'd0) ||
                                     ((dec.wait_code == 2'd3) && ext_ready));
            end
            ws_count: fire = (cnt == 2'd0);
            ws_ext:   fire = ext_ready;
            default:  fire = 1'b0;
        endcase
    end

    // commits line up with the edge that raises ack
    assign reg_commit  = fire && (cur_d.kind == acc_write) && !cur_d.hit;
    assign iack_commit = fire && (cur_d.kind == acc_iack);
    assign reg_idx     = cur_d.reg_idx;
    assign wbyte       = cur_d.wbyte;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ws_idle;
            ack   <= 1'b0;
            cnt   <= '0;
        end else if (fire) begin
            ack   <= 1'b1;
            state <= ws_ack;
        end else begin
            case (state)
                ws_idle: begin
                    if (dec_valid && (dec.wait_code == 2'd3)) begin
                        state <= ws_ext;
                    end else if (dec_valid) begin
                        // codes 1 and 2, one edge already spent here
                        cnt   <= dec.wait_code - 2'd1;
                        state <= ws_count;
                    end
                end
                ws_count: cnt <= cnt - 2'd1;
                // hold until external ready
                ws_ext: state <= ws_ext;
                ws_ack: begin
                    // four-phase release
                    if (!req) begin
                        ack   <= 1'b0;
                        state <= ws_idle;
                    end
                end
                default: state <= ws_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == ws_idle) && dec_valid) begin
            cur <= dec;
        end
        if (fire) begin
            rsp <= '{hit: cur_d.hit, region: cur_d.region, kind: cur_d.kind};
        end
    end

    // ack only answers a pending request
    a_ack_req: assert property (@(posedge clk) disable iff (rst) $rose(ack) |-> $past(req));

    // decode issues at most one transfer at a time
    a_dec_idle: assert property (
        @(posedge clk) disable iff (rst)
        dec_valid |-> state == ws_idle
    );

    a_one_commit: assert property (
        @(posedge clk) disable iff (rst)
        !(reg_commit && iack_commit)
    );

endmodule

//--- hw/region_decode.sv
module region_decode
    import mapper_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        req,
    input  logic        ack,
    input  bus_req_t    bus_req,
    input  region_cfg_t cfg [num_regions],
    output logic        dec_valid,
    output dec_t        dec
);

    // captured request, stage 1
    bus_req_t               req_q;
    logic                   busy;
    logic                   cap_valid;
    logic                   sample;
    // stage 2 decode terms
    acc_e                   kind;
    logic [num_regions-1:0] match;
    logic                   hit;
    region_e                win;

    // compare the address top bits against a region base
    // size code picks how many base bits take part
    function automatic logic base_match(input logic [7:0] top, input region_cfg_t c);
        case (c.size)
            2'd0:    return top == c.base;
            2'd1:    return top[7:1] == c.base[7:1];
            2'd2:    return top[7:3] == c.base[7:3];
            default: return top[7:5] == c.base[7:5];
        endcase
    endfunction

    // one sample per handshake, held off until ack was seen
    assign sample = req && !ack && !busy;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy      <= 1'b0;
            cap_valid <= 1'b0;
            dec_valid <= 1'b0;
        end else begin
            cap_valid <= sample;
            dec_valid <= cap_valid;
            if (sample) begin
                busy <= 1'b1;
            end else if (ack) begin
                busy <= 1'b0;
            end
        end
    end

    always_comb begin
        kind = (req_q.fc == fc_iack) ? acc_iack : (req_q.write ? acc_write : acc_read);
        // iack never lands in a region
        for (int r = 0; r < num_regions; r++) begin
            match[r] = (kind != acc_iack) && base_match(req_q.addr[addr_w -: 8], cfg[r]);
        end
        hit = |match;
        // walk down so the lowest index is left standing
        win = rgn_prog_rom;
        for (int r = num_regions - 1; r >= 0; r--) begin
            if (match[r]) begin
                win = region_e'(3'(r));
            end
        end
    end

    // payload only, qualified by the valid bits above
    always_ff @(posedge clk) begin
        if (sample) begin
            req_q <= bus_req;
        end
        if (cap_valid) begin
            dec.kind      <= kind;
            dec.hit       <= hit;
            dec.region    <= win;
            // misses run as the shortest wait
            dec.wait_code <= hit ? cfg[win].wait_code : 2'd0;
            dec.reg_idx   <= req_q.addr[5:1];
            dec.wbyte     <= req_q.wdata[7:0];
        end
    end

endmodule

//--- hw/mapper_regs.sv
module mapper_regs
    import mapper_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        commit,
    input  logic [4:0]  reg_idx,
    input  logic [7:0]  wbyte,
    input  logic        snd_rd,
    output region_cfg_t cfg [num_regions],
    output logic [7:0]  snd_dout,
    output logic        snd_full
);

    // byte wide mapper registers
    logic [7:0] regs [reg_count];
    // write landing in the sound latch
    logic       snd_wr;

    assign snd_wr = commit && (reg_idx == 5'(snd_latch_idx));

    // register writes come only from unmatched cpu writes
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (commit) begin
            regs[reg_idx] <= wbyte;
        end
    end

    // latch full flag toward the sound cpu
    // a new byte beats a read in the same cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            snd_full <= 1'b0;
        end else if (snd_wr) begin
            snd_full <= 1'b1;
        end else if (snd_rd) begin
            snd_full <= 1'b0;
        end
    end

    assign snd_dout = regs[snd_latch_idx];

    // unpack the region table
    // wait code in bits 3:2 and size code in bits 1:0 of the size/wait byte
    always_comb begin
        for (int r = 0; r < num_regions; r++) begin
            cfg[r].base      = regs[region_reg_base + 2 * r + 1];
            cfg[r].size      = regs[region_reg_base + 2 * r][1:0];
            cfg[r].wait_code = regs[region_reg_base + 2 * r][3:2];
        end
    end

    // the wait stage must only commit a known, in-range index
    a_commit_idx: assert property (
        @(posedge clk) disable iff (rst)
        commit |-> !$isunknown(reg_idx) && (32'(reg_idx) < reg_count)
    );

endmodule

//--- hw/mapper_pkg.sv
package mapper_pkg;

    // cpu bus geometry
    // word address, bit 1 of the byte address is the lsb
    localparam int unsigned addr_w = 23;
    localparam int unsigned data_w = 16;

    // register file layout
    localparam int unsigned num_regions = 8;
    localparam int unsigned reg_count = 32;
    // byte handed over to the sound cpu
    localparam int unsigned snd_latch_idx = 3;
    // region r: size/wait byte at base+2r, base byte at base+2r+1
    localparam int unsigned region_reg_base = 16;

    // function code seen on an interrupt acknowledge cycle
    localparam logic [2:0] fc_iack = 3'b111;

    // region numbering follows the board memory map
    typedef enum logic [2:0] {
        rgn_prog_rom  = 3'd0,
        rgn_unused1   = 3'd1,
        rgn_unused2   = 3'd2,
        rgn_work_ram  = 3'd3,
        rgn_text_ram  = 3'd4,
        rgn_obj_ram   = 3'd5,
        rgn_color_ram = 3'd6,
        rgn_io        = 3'd7
    } region_e;

    // kind of bus cycle, iack overrides read/write
    typedef enum logic [1:0] {
        acc_read  = 2'd0,
        acc_write = 2'd1,
        acc_iack  = 2'd2
    } acc_e;

    // wait stage fsm
    typedef enum logic [1:0] {
        ws_idle  = 2'd0,
        ws_count = 2'd1,
        ws_ext   = 2'd2,
        ws_ack   = 2'd3
    } wait_state_e;

    // one cpu bus cycle as presented with req
    typedef struct packed {
        logic [addr_w:1]   addr;
        logic [data_w-1:0] wdata;
        logic              write;
        logic [2:0]        fc;
    } bus_req_t;

    // decode result handed to the wait stage
    typedef struct packed {
        acc_e       kind;
        logic       hit;
        region_e    region;
        logic [1:0] wait_code;
        // register write target for unmatched writes
        logic [4:0] reg_idx;
        logic [7:0] wbyte;
    } dec_t;

    // per region view of the register file
    typedef struct packed {
        logic [7:0] base;
        logic [1:0] size;
        logic [1:0] wait_code;
    } region_cfg_t;

    // reported with every ack
    typedef struct packed {
        logic    hit;
        region_e region;
        acc_e    kind;
    } map_rsp_t;

endpackage
